// File: Bender.yml
package:
  name: move_eval

sources:
  - logic/move_eval_pkg.sv
  - logic/step_check.sv
  - logic/point_score.sv
  - logic/move_fsm.sv
  - logic/first_move_stage.sv
  - logic/reply_stage.sv
  - logic/best_select.sv
  - logic/move_eval_top.sv
  - target: test
    files:
      - bench/tb_move_eval.sv

// File: bench/tb_move_eval.sv
`timescale 1ns/100ps
`default_nettype none

module tb_move_eval;
    import move_eval_pkg::*;

    localparam int coord_w    = 8;
    localparam int wait_limit = 20;

    logic               clk;
    logic               rst;
    logic               start;
    dir_t               direction;
    color_t             color;
    logic [coord_w-1:0] current_x;
    logic [coord_w-1:0] current_y;
    logic [coord_w-1:0] width;
    logic [coord_w-1:0] length;
    logic [24:0]        status;
    logic [7:0]         centre_lines;
    logic [7:0]         target_lines;
    logic [7:0][7:0]    neighbor_lines;
    logic               idle;
    logic               no_perm;
    logic               no_perm_valid;
    logic               finish;
    logic               my_move;
    logic [score_w-1:0] bestval;

    logic [31:0] lcg_state;
    int          pass_cnt;
    int          fail_cnt;
    int          fails_at_start;

    // expected results of the move in flight
    logic        exp_no_perm;
    logic        exp_my_move;
    logic [7:0]  exp_bestval;

    move_eval_top #(
        .coord_w        (coord_w)
    ) dut_i (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .direction      (direction),
        .color          (color),
        .current_x      (current_x),
        .current_y      (current_y),
        .width          (width),
        .length         (length),
        .status         (status),
        .centre_lines   (centre_lines),
        .target_lines   (target_lines),
        .neighbor_lines (neighbor_lines),
        .idle           (idle),
        .no_perm        (no_perm),
        .no_perm_valid  (no_perm_valid),
        .finish         (finish),
        .my_move        (my_move),
        .bestval        (bestval)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference model

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int step_dx(int d);
        case (d)
            1, 2, 3: return 1;
            5, 6, 7: return -1;
            default: return 0;
        endcase
    endfunction

    function automatic int step_dy(int d);
        case (d)
            7, 0, 1: return 1;
            3, 4, 5: return -1;
            default: return 0;
        endcase
    endfunction

    function automatic bit on_field(int x, int y, int w, int l);
        return (x >= 0) && (x <= w) && (y >= 0) && (y <= l);
    endfunction

    // red counts up from row 0, blue counts down from the far end
    function automatic logic [7:0] point_value(int y, int l, bit is_red, logic [7:0] lines);
        int progress;
        progress = is_red ? y : l - y;
        return 8'(progress + $countones(lines));
    endfunction

    function automatic void ref_eval(output logic np, output logic mm,
                                     output logic [7:0] bv);
        int         d;
        int         tx;
        int         ty;
        int         ox;
        int         oy;
        int         idx;
        logic [7:0] ts;
        logic [7:0] s;
        logic [7:0] hi;
        logic [7:0] lo;
        d  = int'(direction);
        tx = int'(current_x) + step_dx(d);
        ty = int'(current_y) + step_dy(d);
        np = !(status[12 + step_dx(d) - 5 * step_dy(d)] && !centre_lines[d]
               && on_field(tx, ty, int'(width), int'(length)));
        mm = (target_lines != 8'h00) || (tx == 0) || (tx == int'(width))
             || (ty == 0) || (ty == int'(length));
        ts = point_value(ty, int'(length), color == red, target_lines);
        hi = 8'h00;
        lo = 8'hff;
        for (int n = 0; n < 8; n++)
        begin
            ox  = tx + step_dx(n);
            oy  = ty + step_dy(n);
            idx = 12 + step_dx(d) + step_dx(n) - 5 * (step_dy(d) + step_dy(n));
            // no going straight back along the line just drawn
            if (status[idx] && !target_lines[n] && n != (d + 4) % 8
                && on_field(ox, oy, int'(width), int'(length)))
                s = point_value(oy, int'(length), color == red, neighbor_lines[n]);
            else
                s = 8'h00;
            if (s > hi)
                hi = s;
            if (s < lo)
                lo = s;
        end
        bv = ts + (mm ? hi : lo);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks and sequencing

    task automatic compare_value(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
            pass_cnt++;
        else
        begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            fail_cnt++;
        end
    endtask

    task automatic check_true(bit cond, string what);
        assert (cond)
            pass_cnt++;
        else
        begin
            $display("Error: %s", what);
            fail_cnt++;
        end
    endtask

    // cycle 0 is the cycle in which start is high
    task automatic check_response();
        int cyc;
        bit seen;
        cyc  = -1;
        seen = 0;
        while (!seen && cyc < wait_limit)
        begin
            @(negedge clk);
            cyc++;
            if (no_perm_valid)
                seen = 1;
            else
                compare_value("bestval", bestval, 0);
        end
        check_true(seen, "no_perm_valid did not arrive in time");
        if (!seen)
            return;
        check_true(cyc == 1, $sformatf("no_perm_valid came in cycle %0d, not 1", cyc));
        compare_value("no_perm", no_perm, exp_no_perm);
        if (no_perm)
        begin
            @(negedge clk);
            compare_value("idle", idle, 1);
            compare_value("finish", finish, 0);
            compare_value("no_perm_valid", no_perm_valid, 0);
            return;
        end
        seen = 0;
        while (!seen && cyc < wait_limit)
        begin
            @(negedge clk);
            cyc++;
            if (finish)
                seen = 1;
            else
            begin
                compare_value("bestval", bestval, 0);
                compare_value("no_perm_valid", no_perm_valid, 0);
            end
        end
        check_true(seen, "finish did not arrive after a legal move");
        if (!seen)
            return;
        check_true(cyc == 3, $sformatf("finish came in cycle %0d, not 3", cyc));
        compare_value("my_move", my_move, exp_my_move);
        compare_value("bestval", bestval, exp_bestval);
        @(negedge clk);
        compare_value("idle", idle, 1);
        compare_value("bestval", bestval, 0);
    endtask

    task automatic run_move();
        int tries;
        tries = 0;
        while (!idle && tries < wait_limit)
        begin
            @(posedge clk);
            #1;
            tries++;
        end
        check_true(idle, "evaluator stayed busy before start");
        ref_eval(exp_no_perm, exp_my_move, exp_bestval);
        fork
            begin
                start = 1'b1;
                @(posedge clk);
                #1;
                start = 1'b0;
            end
            check_response();
        join
        @(posedge clk);
        #1;
    endtask

    task automatic set_board();
        width          = 8'd10;
        length         = 8'd12;
        current_x      = 8'd5;
        current_y      = 8'd6;
        status         = '1;
        centre_lines   = 8'h00;
        target_lines   = 8'h00;
        neighbor_lines = 64'h0103_070f_1f3f_7fff;
        color          = red;
        direction      = dir_n;
    endtask

    task automatic end_test(string name);
        if (fail_cnt == fails_at_start)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, fail_cnt - fails_at_start);
        fails_at_start = fail_cnt;
    endtask

    initial
    begin : main
        lcg_state      = 32'h6436a34f;
        pass_cnt       = 0;
        fail_cnt       = 0;
        fails_at_start = 0;
        rst            = 1'b1;
        start          = 1'b0;
        set_board();
        repeat (8)
            @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;

        status = ~(25'd1 << 13);
        direction = dir_e;
        run_move();
        end_test("blocked target point");

        set_board();
        centre_lines = 8'h01;
        run_move();
        set_board();
        current_x = width;
        direction = dir_e;
        run_move();
        set_board();
        current_y = 8'd0;
        direction = dir_sw;
        run_move();
        end_test("used line and off field");

        set_board();
        direction    = dir_ne;
        target_lines = 8'h81;
        status[4]    = 1'b0;
        run_move();
        end_test("bounce takes maximum");

        set_board();
        direction = dir_e;
        run_move();
        end_test("plain move takes minimum");

        set_board();
        direction    = dir_se;
        target_lines = 8'h20;
        run_move();
        color = blue;
        run_move();
        end_test("red and blue progress");

        for (int i = 0; i < 200; i++)
        begin
            width          = 8'(2 + (next_rand() >> 8) % 14);
            length         = 8'(2 + (next_rand() >> 8) % 14);
            current_x      = 8'((next_rand() >> 8) % (width + 1));
            current_y      = 8'((next_rand() >> 8) % (length + 1));
            direction      = dir_t'(3'(next_rand() >> 10));
            color          = color_t'(1'(next_rand() >> 12));
            status         = 25'(next_rand() | next_rand());
            centre_lines   = 8'(next_rand() & next_rand() & next_rand());
            target_lines   = 8'(next_rand() & next_rand());
            if (next_rand() & 32'h100)
                target_lines = 8'h00;
            neighbor_lines = {next_rand(), next_rand()};
            run_move();
        end
        end_test("random moves");

        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
logic/move_eval_pkg.sv
logic/step_check.sv
logic/point_score.sv
logic/move_fsm.sv
logic/first_move_stage.sv
logic/reply_stage.sv
logic/best_select.sv
logic/move_eval_top.sv
bench/tb_move_eval.sv

// File: logic/best_select.sv
`timescale 1ns/100ps
`default_nettype none

module best_select #(
    parameter int coord_w = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  decide_en,
    input  wire logic                  my_move,
    input  wire logic [move_eval_pkg::num_dirs-1:0][move_eval_pkg::score_w-1:0] scores,
    input  wire logic [coord_w-1:0]    nloc_y,
    input  wire logic [coord_w-1:0]    length,
    input  wire move_eval_pkg::color_t color,
    input  wire logic [7:0]            target_lines,
    output logic      [move_eval_pkg::score_w-1:0] bestval
);
    import move_eval_pkg::*;

    logic [score_w-1:0] target_score;
    logic [score_w-1:0] max_s;
    logic [score_w-1:0] min_s;

    point_score #(
        .coord_w (coord_w)
    ) u_target (
        .y       (nloc_y),
        .length  (length),
        .color   (color),
        .lines   (target_lines),
        .legal   (1'b1),
        .score   (target_score)
    );

    // refused onward moves count as zero
    always_comb
    begin
        max_s = scores[0];
        min_s = scores[0];
        for (int n = 1; n < num_dirs; n++)
        begin
            if (scores[n] > max_s)
                max_s = scores[n];
            if (scores[n] < min_s)
                min_s = scores[n];
        end
    end

    // mover's own turn takes the best reply, else assume the worst
    always_comb
    begin
        if (!decide_en)
            bestval = '0;
        else if (my_move)
            bestval = target_score + max_s;
        else
            bestval = target_score + min_s;
    end

    a_bestval_quiet: assert property (@(posedge clk) disable iff (rst)
        !decide_en |-> (bestval == '0));

endmodule

`default_nettype wire

// File: logic/first_move_stage.sv
`timescale 1ns/100ps
`default_nettype none

module first_move_stage #(
    parameter int coord_w = 8
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                perm_en,
    input  wire move_eval_pkg::dir_t direction,
    input  wire logic [coord_w-1:0]  current_x,
    input  wire logic [coord_w-1:0]  current_y,
    input  wire logic [coord_w-1:0]  width,
    input  wire logic [coord_w-1:0]  length,
    input  wire logic [24:0]         status,
    input  wire logic [7:0]          centre_lines,
    input  wire logic [7:0]          target_lines,
    output logic                     no_perm,
    output logic                     no_perm_valid,
    output logic      [coord_w-1:0]  nloc_x,
    output logic      [coord_w-1:0]  nloc_y,
    output logic      [4:0]          target_idx,
    output logic                     my_move
);
    import move_eval_pkg::*;

    logic [4:0]         idx;
    logic [coord_w-1:0] to_x;
    logic [coord_w-1:0] to_y;
    logic               legal;
    logic               on_border;

    // target sits at most one row and column off the window centre
    assign idx = 5'(win_centre + int'(dir_dx(direction)) - 5 * int'(dir_dy(direction)));

    step_check #(
        .coord_w   (coord_w)
    ) u_step (
        .from_x    (current_x),
        .from_y    (current_y),
        .width     (width),
        .length    (length),
        .dir       (direction),
        .point_ok  (status[idx]),
        .line_used (centre_lines[direction]),
        .blocked   (1'b0),
        .to_x      (to_x),
        .to_y      (to_y),
        .legal     (legal)
    );

    assign on_border = (to_x == '0) || (to_x == width) || (to_y == '0) || (to_y == length);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            no_perm       <= 1'b0;
            no_perm_valid <= 1'b0;
        end
        else
        begin
            no_perm_valid <= perm_en;
            if (perm_en)
                no_perm <= !legal;
        end
    end

    // bounce when the ball lands on an old line or on the border
    always_ff @(posedge clk)
    begin
        if (perm_en)
        begin
            nloc_x     <= to_x;
            nloc_y     <= to_y;
            target_idx <= idx;
            my_move    <= (target_lines != 8'h00) || on_border;
        end
    end

endmodule

`default_nettype wire

// File: logic/move_eval_pkg.sv
`default_nettype none

package move_eval_pkg;

    // compass order with north at y+1 and east at x+1
    typedef enum logic [2:0] {
        dir_n,
        dir_ne,
        dir_e,
        dir_se,
        dir_s,
        dir_sw,
        dir_w,
        dir_nw
    } dir_t;

    typedef enum logic {
        blue = 1'b0,
        red  = 1'b1
    } color_t;

    typedef enum logic [1:0] {
        st_idle,
        st_perm_check,
        st_new_location,
        st_make_decision
    } ctrl_state_t;

    localparam int num_dirs   = 8;
    localparam int win_size   = 25;
    localparam int win_centre = 12;
    localparam int score_w    = 8;

    function automatic logic signed [1:0] dir_dx(dir_t d);
        case (d)
            dir_ne, dir_e, dir_se: return 2'sd1;
            dir_sw, dir_w, dir_nw: return -2'sd1;
            default:               return 2'sd0;
        endcase
    endfunction

    function automatic logic signed [1:0] dir_dy(dir_t d);
        case (d)
            dir_nw, dir_n, dir_ne: return 2'sd1;
            dir_se, dir_s, dir_sw: return -2'sd1;
            default:               return 2'sd0;
        endcase
    endfunction

    // opposite side of the compass
    function automatic dir_t dir_reverse(dir_t d);
        return dir_t'(d + 3'd4);
    endfunction

endpackage

`default_nettype wire

// File: logic/move_eval_top.sv
`timescale 1ns/100ps
`default_nettype none

module move_eval_top #(
    parameter int coord_w = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  start,
    input  wire move_eval_pkg::dir_t   direction,
    input  wire move_eval_pkg::color_t color,
    input  wire logic [coord_w-1:0]    current_x,
    input  wire logic [coord_w-1:0]    current_y,
    input  wire logic [coord_w-1:0]    width,
    input  wire logic [coord_w-1:0]    length,
    input  wire logic [24:0]           status,
    input  wire logic [7:0]            centre_lines,
    input  wire logic [7:0]            target_lines,
    input  wire logic [move_eval_pkg::num_dirs-1:0][7:0] neighbor_lines,
    output logic                       idle,
    output logic                       no_perm,
    output logic                       no_perm_valid,
    output logic                       finish,
    output logic                       my_move,
    output logic [move_eval_pkg::score_w-1:0] bestval
);
    import move_eval_pkg::*;

    logic                             perm_en;
    logic                             new_loc_en;
    logic                             decide_en;
    logic [coord_w-1:0]               nloc_x;
    logic [coord_w-1:0]               nloc_y;
    logic [4:0]                       target_idx;
    logic [num_dirs-1:0][score_w-1:0] scores;

    move_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .no_perm    (no_perm),
        .idle       (idle),
        .perm_en    (perm_en),
        .new_loc_en (new_loc_en),
        .decide_en  (decide_en),
        .finish     (finish)
    );

    first_move_stage #(
        .coord_w       (coord_w)
    ) u_first (
        .clk           (clk),
        .rst           (rst),
        .perm_en       (perm_en),
        .direction     (direction),
        .current_x     (current_x),
        .current_y     (current_y),
        .width         (width),
        .length        (length),
        .status        (status),
        .centre_lines  (centre_lines),
        .target_lines  (target_lines),
        .no_perm       (no_perm),
        .no_perm_valid (no_perm_valid),
        .nloc_x        (nloc_x),
        .nloc_y        (nloc_y),
        .target_idx    (target_idx),
        .my_move       (my_move)
    );

    reply_stage #(
        .coord_w        (coord_w)
    ) u_reply (
        .clk            (clk),
        .rst            (rst),
        .new_loc_en     (new_loc_en),
        .direction      (direction),
        .color          (color),
        .nloc_x         (nloc_x),
        .nloc_y         (nloc_y),
        .width          (width),
        .length         (length),
        .target_idx     (target_idx),
        .status         (status),
        .target_lines   (target_lines),
        .neighbor_lines (neighbor_lines),
        .scores         (scores)
    );

    best_select #(
        .coord_w      (coord_w)
    ) u_best (
        .clk          (clk),
        .rst          (rst),
        .decide_en    (decide_en),
        .my_move      (my_move),
        .scores       (scores),
        .nloc_y       (nloc_y),
        .length       (length),
        .color        (color),
        .target_lines (target_lines),
        .bestval      (bestval)
    );

endmodule

`default_nettype wire

// File: logic/move_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module move_fsm (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic start,
    input  wire logic no_perm,
    output logic      idle,
    output logic      perm_en,
    output logic      new_loc_en,
    output logic      decide_en,
    output logic      finish
);
    import move_eval_pkg::*;

    ctrl_state_t state;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= st_idle;
        else
        begin
            case (state)
                st_idle:
                    if (start)
                        state <= st_perm_check;
                st_perm_check:
                    // refused move goes straight back
                    state <= no_perm ? st_idle : st_new_location;
                st_new_location:
                    state <= st_make_decision;
                default:
                    state <= st_idle;
            endcase
        end
    end

    assign idle       = (state == st_idle);
    assign perm_en    = idle && start;
    assign new_loc_en = (state == st_new_location);
    assign decide_en  = (state == st_make_decision);
    assign finish     = decide_en;

    //////////////////////////////////////////////////////////////////////
    // protocol checks

    a_finish_single: assert property (@(posedge clk) disable iff (rst)
        finish |=> !finish);

    a_idle_needs_start: assert property (@(posedge clk) disable iff (rst)
        (state == st_idle && !start) |=> (state == st_idle));

endmodule

`default_nettype wire

// File: logic/point_score.sv
`timescale 1ns/100ps
`default_nettype none

module point_score #(
    parameter int coord_w = 8
) (
    input  wire logic [coord_w-1:0]                y,
    input  wire logic [coord_w-1:0]                length,
    input  wire move_eval_pkg::color_t             color,
    input  wire logic [7:0]                        lines,
    input  wire logic                              legal,
    output logic      [move_eval_pkg::score_w-1:0] score
);
    import move_eval_pkg::*;

    logic [coord_w-1:0] progress;
    logic [3:0]         line_cnt;

    // red heads up the field, blue heads down
    assign progress = (color == red) ? y : length - y;

    always_comb
    begin
        line_cnt = '0;
        for (int n = 0; n < 8; n++)
            line_cnt = line_cnt + 4'(lines[n]);
    end

    assign score = legal ? score_w'(progress) + score_w'(line_cnt) : '0;

endmodule

`default_nettype wire

// File: logic/reply_stage.sv
`timescale 1ns/100ps
`default_nettype none

module reply_stage #(
    parameter int coord_w = 8
) (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  new_loc_en,
    input  wire move_eval_pkg::dir_t   direction,
    input  wire move_eval_pkg::color_t color,
    input  wire logic [coord_w-1:0]    nloc_x,
    input  wire logic [coord_w-1:0]    nloc_y,
    input  wire logic [coord_w-1:0]    width,
    input  wire logic [coord_w-1:0]    length,
    input  wire logic [4:0]            target_idx,
    input  wire logic [24:0]           status,
    input  wire logic [7:0]            target_lines,
    input  wire logic [move_eval_pkg::num_dirs-1:0][7:0] neighbor_lines,
    output logic [move_eval_pkg::num_dirs-1:0][move_eval_pkg::score_w-1:0] scores
);
    import move_eval_pkg::*;

    logic [num_dirs-1:0]              legal;
    logic [num_dirs-1:0]              legal_q;
    logic [num_dirs-1:0][coord_w-1:0] to_y;
    logic [num_dirs-1:0][coord_w-1:0] to_y_q;

    //////////////////////////////////////////////////////////////////////
    // one checker and one scorer per onward direction

    for (genvar n = 0; n < num_dirs; n++)
    begin : g_dir
        localparam int win_off = dir_dx(dir_t'(n)) - 5 * dir_dy(dir_t'(n));

        logic [4:0] idx;

        // offset wraps mod 32, the result stays inside the window
        assign idx = target_idx + 5'(win_off);

        step_check #(
            .coord_w   (coord_w)
        ) u_step (
            .from_x    (nloc_x),
            .from_y    (nloc_y),
            .width     (width),
            .length    (length),
            .dir       (dir_t'(n)),
            .point_ok  (status[idx]),
            .line_used (target_lines[n]),
            .blocked   (dir_t'(n) == dir_reverse(direction)),
            .to_x      (),
            .to_y      (to_y[n]),
            .legal     (legal[n])
        );

        point_score #(
            .coord_w (coord_w)
        ) u_score (
            .y       (to_y_q[n]),
            .length  (length),
            .color   (color),
            .lines   (neighbor_lines[n]),
            .legal   (legal_q[n]),
            .score   (scores[n])
        );
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            legal_q <= '0;
        else if (new_loc_en)
            legal_q <= legal;
    end

    always_ff @(posedge clk)
    begin
        if (new_loc_en)
            to_y_q <= to_y;
    end

endmodule

`default_nettype wire

// File: logic/step_check.sv
`timescale 1ns/100ps
`default_nettype none

module step_check #(
    parameter int coord_w = 8
) (
    input  wire logic [coord_w-1:0]   from_x,
    input  wire logic [coord_w-1:0]   from_y,
    input  wire logic [coord_w-1:0]   width,
    input  wire logic [coord_w-1:0]   length,
    input  wire move_eval_pkg::dir_t  dir,
    input  wire logic                 point_ok,
    input  wire logic                 line_used,
    input  wire logic                 blocked,
    output logic      [coord_w-1:0]   to_x,
    output logic      [coord_w-1:0]   to_y,
    output logic                      legal
);
    import move_eval_pkg::*;

    // two extra bits hold the sign and the carry past the top edge
    logic signed [coord_w+1:0] nx;
    logic signed [coord_w+1:0] ny;
    logic                      x_in;
    logic                      y_in;

    always_comb
    begin
        nx = $signed({2'b00, from_x}) + dir_dx(dir);
        ny = $signed({2'b00, from_y}) + dir_dy(dir);
    end

    // negative or past the field edge means off the board
    assign x_in = !nx[coord_w+1] && (nx[coord_w:0] <= {1'b0, width});
    assign y_in = !ny[coord_w+1] && (ny[coord_w:0] <= {1'b0, length});

    assign to_x  = nx[coord_w-1:0];
    assign to_y  = ny[coord_w-1:0];
    assign legal = point_ok && !line_used && !blocked && x_in && y_in;

endmodule

`default_nettype wire
